// ==== source/tank_cfg.svh ====
// ======================================================================
// Tank duel configuration
// Arena and object sizes, step sizes, key codes, start positions and
// the fixed barrier boxes
// ======================================================================
`ifndef TANK_CFG_SVH
`define TANK_CFG_SVH

// Arena and object sizes
`define TANK_ARENA_W        640
`define TANK_ARENA_H        480
`define TANK_HALF           8
`define TANK_BULLET_HALF    2

// Per-frame steps
`define TANK_STEP           2
`define TANK_BULLET_STEP    8

// Keyboard usage codes
`define TANK_KEY_P1_UP      8'h1A  // W
`define TANK_KEY_P1_DOWN    8'h16  // S
`define TANK_KEY_P1_LEFT    8'h04  // A
`define TANK_KEY_P1_RIGHT   8'h07  // D
`define TANK_KEY_P2_UP      8'h52  // Arrow keys
`define TANK_KEY_P2_DOWN    8'h51
`define TANK_KEY_P2_LEFT    8'h50
`define TANK_KEY_P2_RIGHT   8'h4F
`define TANK_KEY_P1_FIRE    8'h2C  // Space
`define TANK_KEY_P2_FIRE    8'h28  // Enter

// Start positions
`define TANK_P1_START_X     100
`define TANK_P1_START_Y     240
`define TANK_P2_START_X     540
`define TANK_P2_START_Y     240

// Fixed barriers as centre, half height, half width
`define TANK_BARRIER_COUNT  3
`define TANK_BARRIER_1_X    320
`define TANK_BARRIER_1_Y    200
`define TANK_BARRIER_1_HH   10
`define TANK_BARRIER_1_HW   40
`define TANK_BARRIER_2_X    320
`define TANK_BARRIER_2_Y    240
`define TANK_BARRIER_2_HH   30
`define TANK_BARRIER_2_HW   20
`define TANK_BARRIER_3_X    320
`define TANK_BARRIER_3_Y    280
`define TANK_BARRIER_3_HH   10
`define TANK_BARRIER_3_HW   40

`endif

// ==== source/tank_pkg.sv ====
// ======================================================================
// Tank duel package
// Shared coordinate, score, keycode and object state types, plus the
// box overlap rule used by every collision check
// ======================================================================
`default_nettype none

package tank_pkg;

	typedef logic [9:0] coord_t;    // Screen coordinate
	typedef logic [7:0] score_t;    // Wraps at 256
	typedef logic [7:0] keycode_t;  // Keyboard usage code

	typedef enum logic [1:0] {
		DIR_UP    = 2'd0,
		DIR_DOWN  = 2'd1,
		DIR_LEFT  = 2'd2,
		DIR_RIGHT = 2'd3
	} dir_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
		dir_t   dir;
	} tank_state_t;

	typedef struct packed {
		logic   active;
		coord_t x;
		coord_t y;
		dir_t   dir;
	} bullet_state_t;

	// Two boxes overlap when both centre distances are below the summed halves
	function automatic logic boxes_overlap(
		input coord_t ax,
		input coord_t ay,
		input coord_t bx,
		input coord_t by,
		input int     sum_hw,
		input int     sum_hh
	);
		int dx;
		int dy;
		dx = (ax > bx) ? int'(ax - bx) : int'(bx - ax);
		dy = (ay > by) ? int'(ay - by) : int'(by - ay);
		return (dx < sum_hw) && (dy < sum_hh);
	endfunction

endpackage

`default_nettype wire

// ==== source/tank_motion.sv ====
// ======================================================================
// Tank motion
// Position and facing of one tank, stepped from its movement keycode
// with the arena edge limit; barriers come back as blocked
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

`include "tank_cfg.svh"

module tank_motion #(
	parameter tank_pkg::keycode_t key_up    = 8'h00,
	parameter tank_pkg::keycode_t key_down  = 8'h00,
	parameter tank_pkg::keycode_t key_left  = 8'h00,
	parameter tank_pkg::keycode_t key_right = 8'h00,
	parameter tank_pkg::coord_t   start_x   = 10'd0,
	parameter tank_pkg::coord_t   start_y   = 10'd0,
	parameter tank_pkg::dir_t     start_dir = tank_pkg::DIR_UP
) (
	input  wire logic                  frame_clk,
	input  wire logic                  arst_n,
	input  wire tank_pkg::keycode_t    key,
	input  wire logic                  blocked,
	input  wire logic                  new_round,
	output tank_pkg::tank_state_t      tank,
	output tank_pkg::tank_state_t      candidate
);

	localparam tank_pkg::tank_state_t start_state = '{x: start_x, y: start_y, dir: start_dir};

	logic           move_key;
	tank_pkg::dir_t cand_dir;
	int             next_x;
	int             next_y;
	logic           edge_out;

	// Key decode
	always_comb begin
		move_key = 1'b1;
		cand_dir = tank.dir;
		case (key)
			key_up:    cand_dir = tank_pkg::DIR_UP;
			key_down:  cand_dir = tank_pkg::DIR_DOWN;
			key_left:  cand_dir = tank_pkg::DIR_LEFT;
			key_right: cand_dir = tank_pkg::DIR_RIGHT;
			default:   move_key = 1'b0;
		endcase
	end

	// One step ahead in the new direction
	always_comb begin
		next_x = int'(tank.x);
		next_y = int'(tank.y);
		case (cand_dir)
			tank_pkg::DIR_UP:    next_y = int'(tank.y) - `TANK_STEP;
			tank_pkg::DIR_DOWN:  next_y = int'(tank.y) + `TANK_STEP;
			tank_pkg::DIR_LEFT:  next_x = int'(tank.x) - `TANK_STEP;
			default:             next_x = int'(tank.x) + `TANK_STEP;
		endcase
		edge_out = (next_x < `TANK_HALF) || (next_x > `TANK_ARENA_W - 1 - `TANK_HALF) ||
			(next_y < `TANK_HALF) || (next_y > `TANK_ARENA_H - 1 - `TANK_HALF);
	end

	// Held position when the edge stops the tank or no move is requested
	always_comb begin
		candidate = tank;
		if (move_key) begin
			candidate.dir = cand_dir;
			if (!edge_out) begin
				candidate.x = tank_pkg::coord_t'(next_x);
				candidate.y = tank_pkg::coord_t'(next_y);
			end
		end
	end

	always_ff @(posedge frame_clk or negedge arst_n) begin
		if (!arst_n) begin
			tank <= start_state;
		end else if (new_round) begin
			tank <= start_state;  // Round restart wins over keys
		end else if (move_key) begin
			if (blocked)
				tank.dir <= candidate.dir;  // Turn in place against a barrier
			else
				tank <= candidate;
		end
	end

endmodule

`default_nettype wire

// ==== source/bullet_motion.sv ====
// ======================================================================
// Bullet motion
// One tank's bullet: spawn at the tank centre on the fire key, travel
// in the firing direction, removal at the arena edge or a barrier
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

`include "tank_cfg.svh"

module bullet_motion #(
	parameter tank_pkg::keycode_t key_fire = 8'h00
) (
	input  wire logic                  frame_clk,
	input  wire logic                  arst_n,
	input  wire tank_pkg::keycode_t    key,
	input  wire tank_pkg::tank_state_t tank,
	input  wire logic                  barrier_hit,
	input  wire logic                  new_round,
	output tank_pkg::bullet_state_t    bullet
);

	int   next_x;
	int   next_y;
	logic leaves_arena;
	logic fire;

	assign fire = (key == key_fire);

	// Next centre along the travel direction
	always_comb begin
		next_x = int'(bullet.x);
		next_y = int'(bullet.y);
		case (bullet.dir)
			tank_pkg::DIR_UP:    next_y = int'(bullet.y) - `TANK_BULLET_STEP;
			tank_pkg::DIR_DOWN:  next_y = int'(bullet.y) + `TANK_BULLET_STEP;
			tank_pkg::DIR_LEFT:  next_x = int'(bullet.x) - `TANK_BULLET_STEP;
			default:             next_x = int'(bullet.x) + `TANK_BULLET_STEP;
		endcase
		leaves_arena = (next_x < 0) || (next_x > `TANK_ARENA_W - 1) ||
			(next_y < 0) || (next_y > `TANK_ARENA_H - 1);
	end

	// ==================================================================
	// Bullet state
	// ==================================================================
	always_ff @(posedge frame_clk or negedge arst_n) begin
		if (!arst_n) begin
			bullet <= '0;
		end else if (new_round) begin
			bullet.active <= 1'b0;
		end else if (!bullet.active) begin
			if (fire) begin
				bullet.active <= 1'b1;
				bullet.x      <= tank.x;
				bullet.y      <= tank.y;
				bullet.dir    <= tank.dir;
			end
		end else if (barrier_hit || leaves_arena) begin
			bullet.active <= 1'b0;  // Last x and y stay put
		end else begin
			bullet.x <= tank_pkg::coord_t'(next_x);
			bullet.y <= tank_pkg::coord_t'(next_y);
		end
	end

endmodule

`default_nettype wire

// ==== source/barrier_field.sv ====
// ======================================================================
// Barrier field
// Overlap of the tank candidates and the bullets with the fixed
// barriers, one check per barrier, ORed together
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

`include "tank_cfg.svh"

module barrier_field (
	input  wire tank_pkg::tank_state_t   cand_p1,
	input  wire tank_pkg::tank_state_t   cand_p2,
	input  wire tank_pkg::bullet_state_t bullet_p1,
	input  wire tank_pkg::bullet_state_t bullet_p2,
	output logic                         blocked_p1,
	output logic                         blocked_p2,
	output logic                         barrier_hit_p1,
	output logic                         barrier_hit_p2
);

	localparam int bar_x  [`TANK_BARRIER_COUNT] = '{`TANK_BARRIER_1_X,
		`TANK_BARRIER_2_X, `TANK_BARRIER_3_X};
	localparam int bar_y  [`TANK_BARRIER_COUNT] = '{`TANK_BARRIER_1_Y,
		`TANK_BARRIER_2_Y, `TANK_BARRIER_3_Y};
	localparam int bar_hh [`TANK_BARRIER_COUNT] = '{`TANK_BARRIER_1_HH,
		`TANK_BARRIER_2_HH, `TANK_BARRIER_3_HH};
	localparam int bar_hw [`TANK_BARRIER_COUNT] = '{`TANK_BARRIER_1_HW,
		`TANK_BARRIER_2_HW, `TANK_BARRIER_3_HW};

	logic [`TANK_BARRIER_COUNT-1:0] tank_hit_p1;
	logic [`TANK_BARRIER_COUNT-1:0] tank_hit_p2;
	logic [`TANK_BARRIER_COUNT-1:0] shot_hit_p1;
	logic [`TANK_BARRIER_COUNT-1:0] shot_hit_p2;

	for (genvar i = 0; i < `TANK_BARRIER_COUNT; i++) begin : g_barrier
		assign tank_hit_p1[i] = tank_pkg::boxes_overlap(cand_p1.x, cand_p1.y,
			tank_pkg::coord_t'(bar_x[i]), tank_pkg::coord_t'(bar_y[i]),
			`TANK_HALF + bar_hw[i], `TANK_HALF + bar_hh[i]);
		assign tank_hit_p2[i] = tank_pkg::boxes_overlap(cand_p2.x, cand_p2.y,
			tank_pkg::coord_t'(bar_x[i]), tank_pkg::coord_t'(bar_y[i]),
			`TANK_HALF + bar_hw[i], `TANK_HALF + bar_hh[i]);
		assign shot_hit_p1[i] = tank_pkg::boxes_overlap(bullet_p1.x, bullet_p1.y,
			tank_pkg::coord_t'(bar_x[i]), tank_pkg::coord_t'(bar_y[i]),
			`TANK_BULLET_HALF + bar_hw[i], `TANK_BULLET_HALF + bar_hh[i]);
		assign shot_hit_p2[i] = tank_pkg::boxes_overlap(bullet_p2.x, bullet_p2.y,
			tank_pkg::coord_t'(bar_x[i]), tank_pkg::coord_t'(bar_y[i]),
			`TANK_BULLET_HALF + bar_hw[i], `TANK_BULLET_HALF + bar_hh[i]);
	end

	assign blocked_p1     = |tank_hit_p1;
	assign blocked_p2     = |tank_hit_p2;
	assign barrier_hit_p1 = bullet_p1.active & (|shot_hit_p1);  // Parked bullets never hit
	assign barrier_hit_p2 = bullet_p2.active & (|shot_hit_p2);

endmodule

`default_nettype wire

// ==== source/hit_detector.sv ====
// ======================================================================
// Hit detector
// Bullet on enemy tank detection, the two score counters and the
// new round pulse
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

`include "tank_cfg.svh"

module hit_detector (
	input  wire logic                    frame_clk,
	input  wire logic                    arst_n,
	input  wire tank_pkg::tank_state_t   tank_p1,
	input  wire tank_pkg::tank_state_t   tank_p2,
	input  wire tank_pkg::bullet_state_t bullet_p1,
	input  wire tank_pkg::bullet_state_t bullet_p2,
	output tank_pkg::score_t             score_p1,
	output tank_pkg::score_t             score_p2,
	output logic                         new_round
);

	localparam int hit_reach = `TANK_HALF + `TANK_BULLET_HALF;  // Square boxes

	logic hit_by_p1;  // P1 bullet on P2 tank
	logic hit_by_p2;  // P2 bullet on P1 tank

	// Own bullet is never checked against own tank
	assign hit_by_p1 = bullet_p1.active && tank_pkg::boxes_overlap(bullet_p1.x, bullet_p1.y,
		tank_p2.x, tank_p2.y, hit_reach, hit_reach);
	assign hit_by_p2 = bullet_p2.active && tank_pkg::boxes_overlap(bullet_p2.x, bullet_p2.y,
		tank_p1.x, tank_p1.y, hit_reach, hit_reach);

	assign new_round = hit_by_p1 | hit_by_p2;

	// ==================================================================
	// Scores
	// ==================================================================
	always_ff @(posedge frame_clk or negedge arst_n) begin
		if (!arst_n) begin
			score_p1 <= '0;
			score_p2 <= '0;
		end else begin
			if (hit_by_p1)
				score_p1 <= score_p1 + 8'd1;
			if (hit_by_p2)
				score_p2 <= score_p2 + 8'd1;  // Both may score in one frame
		end
	end

endmodule

`default_nettype wire

// ==== source/tank_game_top.sv ====
// ======================================================================
// Tank duel game core
// Two tanks, two bullets, the barrier field and the hit detector,
// all stepped once per frame clock
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

`include "tank_cfg.svh"

module tank_game_top (
	input  wire logic                  frame_clk,
	input  wire logic                  arst_n,
	input  wire tank_pkg::keycode_t    key_p1_move,
	input  wire tank_pkg::keycode_t    key_p2_move,
	input  wire tank_pkg::keycode_t    key_p1_fire,
	input  wire tank_pkg::keycode_t    key_p2_fire,
	output tank_pkg::tank_state_t      tank_p1,
	output tank_pkg::tank_state_t      tank_p2,
	output tank_pkg::bullet_state_t    bullet_p1,
	output tank_pkg::bullet_state_t    bullet_p2,
	output tank_pkg::score_t           score_p1,
	output tank_pkg::score_t           score_p2,
	output logic                       new_round
);

	tank_pkg::tank_state_t cand_p1;
	tank_pkg::tank_state_t cand_p2;
	logic                  blocked_p1;
	logic                  blocked_p2;
	logic                  barrier_hit_p1;
	logic                  barrier_hit_p2;

	// ==================================================================
	// Tanks
	// ==================================================================
	tank_motion #(
		.key_up(`TANK_KEY_P1_UP), .key_down(`TANK_KEY_P1_DOWN),
		.key_left(`TANK_KEY_P1_LEFT), .key_right(`TANK_KEY_P1_RIGHT),
		.start_x(10'(`TANK_P1_START_X)), .start_y(10'(`TANK_P1_START_Y)),
		.start_dir(tank_pkg::DIR_RIGHT)
	) u_tank_p1 (
		.frame_clk, .arst_n, .key(key_p1_move), .blocked(blocked_p1),
		.new_round, .tank(tank_p1), .candidate(cand_p1)
	);

	tank_motion #(
		.key_up(`TANK_KEY_P2_UP), .key_down(`TANK_KEY_P2_DOWN),
		.key_left(`TANK_KEY_P2_LEFT), .key_right(`TANK_KEY_P2_RIGHT),
		.start_x(10'(`TANK_P2_START_X)), .start_y(10'(`TANK_P2_START_Y)),
		.start_dir(tank_pkg::DIR_LEFT)
	) u_tank_p2 (
		.frame_clk, .arst_n, .key(key_p2_move), .blocked(blocked_p2),
		.new_round, .tank(tank_p2), .candidate(cand_p2)
	);

	// ==================================================================
	// Bullets
	// ==================================================================
	bullet_motion #(.key_fire(`TANK_KEY_P1_FIRE)) u_bullet_p1 (
		.frame_clk, .arst_n, .key(key_p1_fire), .tank(tank_p1),
		.barrier_hit(barrier_hit_p1), .new_round, .bullet(bullet_p1)
	);

	bullet_motion #(.key_fire(`TANK_KEY_P2_FIRE)) u_bullet_p2 (
		.frame_clk, .arst_n, .key(key_p2_fire), .tank(tank_p2),
		.barrier_hit(barrier_hit_p2), .new_round, .bullet(bullet_p2)
	);

	barrier_field u_barriers (
		.cand_p1, .cand_p2, .bullet_p1, .bullet_p2,
		.blocked_p1, .blocked_p2, .barrier_hit_p1, .barrier_hit_p2
	);

	hit_detector u_hits (
		.frame_clk, .arst_n, .tank_p1, .tank_p2, .bullet_p1, .bullet_p2,
		.score_p1, .score_p2, .new_round
	);

endmodule

`default_nettype wire

// ==== verification/tank_game_sva.sv ====
// ======================================================================
// Tank duel assertions
// Round restart, score and arena invariants of the game core
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

`include "tank_cfg.svh"

module tank_game_sva (
	input wire logic                    frame_clk,
	input wire logic                    arst_n,
	input wire tank_pkg::tank_state_t   tank_p1,
	input wire tank_pkg::tank_state_t   tank_p2,
	input wire tank_pkg::bullet_state_t bullet_p1,
	input wire tank_pkg::bullet_state_t bullet_p2,
	input wire tank_pkg::score_t        score_p1,
	input wire tank_pkg::score_t        score_p2,
	input wire logic                    new_round
);

	int assert_failures = 0;  // Read by the testbench at the end of the run

	function automatic logic inside_arena(input tank_pkg::tank_state_t t);
		return t.x >= `TANK_HALF && t.x <= `TANK_ARENA_W - 1 - `TANK_HALF &&
			t.y >= `TANK_HALF && t.y <= `TANK_ARENA_H - 1 - `TANK_HALF;
	endfunction

	a_round_clears: assert property (@(posedge frame_clk) disable iff (!arst_n)
		new_round |=> !bullet_p1.active && !bullet_p2.active)
	else begin
		assert_failures++;
		$error("bullet still active after new_round");
	end

	a_score_p1: assert property (@(posedge frame_clk) disable iff (!arst_n)
		score_p1 != $past(score_p1) |->
			$past(new_round) && score_p1 == tank_pkg::score_t'($past(score_p1) + 8'd1))
	else begin
		assert_failures++;
		$error("score_p1 changed without a single step after new_round");
	end

	a_score_p2: assert property (@(posedge frame_clk) disable iff (!arst_n)
		score_p2 != $past(score_p2) |->
			$past(new_round) && score_p2 == tank_pkg::score_t'($past(score_p2) + 8'd1))
	else begin
		assert_failures++;
		$error("score_p2 changed without a single step after new_round");
	end

	// Centres stay a half tank inside the arena
	a_tanks_inside: assert property (@(posedge frame_clk) disable iff (!arst_n)
		inside_arena(tank_p1) && inside_arena(tank_p2))
	else begin
		assert_failures++;
		$error("tank centre outside the arena limits");
	end

endmodule

bind tank_game_top tank_game_sva u_sva (
	.frame_clk, .arst_n, .tank_p1, .tank_p2, .bullet_p1, .bullet_p2,
	.score_p1, .score_p2, .new_round
);

`default_nettype wire

// ==== verification/tank_game_tb.sv ====
// ======================================================================
// Tank duel testbench
// Directed and seeded random keys, every frame checked against a
// reference model of the game rules
// ======================================================================
`timescale 1ns/100ps
`default_nettype none

`include "tank_cfg.svh"

module tank_game_tb;

	localparam int directed_cycles = 200;
	localparam int random_cycles   = 2000;
	localparam int cycle_limit     = directed_cycles + random_cycles + 200;
	localparam int hit_reach       = `TANK_HALF + `TANK_BULLET_HALF;

	localparam tank_pkg::keycode_t up_key [2]    = '{`TANK_KEY_P1_UP, `TANK_KEY_P2_UP};
	localparam tank_pkg::keycode_t down_key [2]  = '{`TANK_KEY_P1_DOWN, `TANK_KEY_P2_DOWN};
	localparam tank_pkg::keycode_t left_key [2]  = '{`TANK_KEY_P1_LEFT, `TANK_KEY_P2_LEFT};
	localparam tank_pkg::keycode_t right_key [2] = '{`TANK_KEY_P1_RIGHT, `TANK_KEY_P2_RIGHT};
	localparam tank_pkg::keycode_t fire_code [2] = '{`TANK_KEY_P1_FIRE, `TANK_KEY_P2_FIRE};

	localparam int bar_x [`TANK_BARRIER_COUNT]  = '{`TANK_BARRIER_1_X, `TANK_BARRIER_2_X,
		`TANK_BARRIER_3_X};
	localparam int bar_y [`TANK_BARRIER_COUNT]  = '{`TANK_BARRIER_1_Y, `TANK_BARRIER_2_Y,
		`TANK_BARRIER_3_Y};
	localparam int bar_hh [`TANK_BARRIER_COUNT] = '{`TANK_BARRIER_1_HH, `TANK_BARRIER_2_HH,
		`TANK_BARRIER_3_HH};
	localparam int bar_hw [`TANK_BARRIER_COUNT] = '{`TANK_BARRIER_1_HW, `TANK_BARRIER_2_HW,
		`TANK_BARRIER_3_HW};

	logic                    frame_clk;
	logic                    arst_n;
	tank_pkg::keycode_t      key_p1_move;
	tank_pkg::keycode_t      key_p2_move;
	tank_pkg::keycode_t      key_p1_fire;
	tank_pkg::keycode_t      key_p2_fire;
	tank_pkg::tank_state_t   tank_p1;
	tank_pkg::tank_state_t   tank_p2;
	tank_pkg::bullet_state_t bullet_p1;
	tank_pkg::bullet_state_t bullet_p2;
	tank_pkg::score_t        score_p1;
	tank_pkg::score_t        score_p2;
	logic                    new_round;

	// Reference model state, index 0 is P1
	tank_pkg::tank_state_t   m_tank [2];
	tank_pkg::bullet_state_t m_bul [2];
	tank_pkg::score_t        m_score [2];
	bit                      m_fired [2];  // Bullet position known once fired
	int                      cycle_count = 0;

	tank_game_top dut (
		.frame_clk(frame_clk), .arst_n(arst_n),
		.key_p1_move(key_p1_move), .key_p2_move(key_p2_move),
		.key_p1_fire(key_p1_fire), .key_p2_fire(key_p2_fire),
		.tank_p1(tank_p1), .tank_p2(tank_p2), .bullet_p1(bullet_p1), .bullet_p2(bullet_p2),
		.score_p1(score_p1), .score_p2(score_p2), .new_round(new_round)
	);

	initial begin
		frame_clk = 1'b0;
		forever #50 frame_clk = ~frame_clk;
	end

	// ==================================================================
	// Reference model
	// ==================================================================
	function automatic bit boxes_touch(input int ax, input int ay, input int bx, input int by,
		input int rx, input int ry);
		return (ax - bx < rx) && (bx - ax < rx) && (ay - by < ry) && (by - ay < ry);
	endfunction

	function automatic bit hits_barrier(input int x, input int y, input int half);
		bit hit;
		hit = 1'b0;
		for (int i = 0; i < `TANK_BARRIER_COUNT; i++)
			hit |= boxes_touch(x, y, bar_x[i], bar_y[i], half + bar_hw[i], half + bar_hh[i]);
		return hit;
	endfunction

	// Active bullet of player p on the other tank
	function automatic bit shot_lands(input int p);
		return m_bul[p].active && boxes_touch(m_bul[p].x, m_bul[p].y,
			m_tank[1 - p].x, m_tank[1 - p].y, hit_reach, hit_reach);
	endfunction

	function automatic tank_pkg::tank_state_t start_tank(input int p);
		tank_pkg::tank_state_t t;
		t.x   = (p == 0) ? 10'(`TANK_P1_START_X) : 10'(`TANK_P2_START_X);
		t.y   = (p == 0) ? 10'(`TANK_P1_START_Y) : 10'(`TANK_P2_START_Y);
		t.dir = (p == 0) ? tank_pkg::DIR_RIGHT : tank_pkg::DIR_LEFT;
		return t;
	endfunction

	task automatic step_point(input int x, input int y, input tank_pkg::dir_t d, input int step,
		output int nx, output int ny);
		nx = x;
		ny = y;
		case (d)
			tank_pkg::DIR_UP:   ny = y - step;
			tank_pkg::DIR_DOWN: ny = y + step;
			tank_pkg::DIR_LEFT: nx = x - step;
			default:            nx = x + step;
		endcase
	endtask

	task automatic reset_model();
		for (int p = 0; p < 2; p++) begin
			m_tank[p]  = start_tank(p);
			m_bul[p]   = '0;
			m_score[p] = 8'd0;
			m_fired[p] = 1'b0;
		end
	endtask

	task automatic advance_model();
		tank_pkg::keycode_t move_in [2];
		tank_pkg::keycode_t fire_in [2];
		bit                 landed [2];
		tank_pkg::dir_t     d;
		bit                 is_move;
		int                 nx;
		int                 ny;
		move_in[0] = key_p1_move;
		move_in[1] = key_p2_move;
		fire_in[0] = key_p1_fire;
		fire_in[1] = key_p2_fire;
		landed[0]  = shot_lands(0);
		landed[1]  = shot_lands(1);
		for (int p = 0; p < 2; p++) begin
			if (landed[0] || landed[1]) begin
				if (landed[p])
					m_score[p] = m_score[p] + 8'd1;  // Wraps at 256
				m_tank[p]       = start_tank(p);
				m_bul[p].active = 1'b0;
			end else begin
				// Bullet before tank, spawn uses the tank before this edge
				if (!m_bul[p].active) begin
					if (fire_in[p] == fire_code[p]) begin
						m_bul[p] = '{active: 1'b1, x: m_tank[p].x, y: m_tank[p].y,
							dir: m_tank[p].dir};
						m_fired[p] = 1'b1;
					end
				end else begin
					step_point(m_bul[p].x, m_bul[p].y, m_bul[p].dir, `TANK_BULLET_STEP, nx, ny);
					if (hits_barrier(m_bul[p].x, m_bul[p].y, `TANK_BULLET_HALF) || nx < 0 ||
						nx > `TANK_ARENA_W - 1 || ny < 0 || ny > `TANK_ARENA_H - 1) begin
						m_bul[p].active = 1'b0;
					end else begin
						m_bul[p].x = tank_pkg::coord_t'(nx);
						m_bul[p].y = tank_pkg::coord_t'(ny);
					end
				end
				is_move = 1'b1;
				d       = m_tank[p].dir;
				if (move_in[p] == up_key[p])
					d = tank_pkg::DIR_UP;
				else if (move_in[p] == down_key[p])
					d = tank_pkg::DIR_DOWN;
				else if (move_in[p] == left_key[p])
					d = tank_pkg::DIR_LEFT;
				else if (move_in[p] == right_key[p])
					d = tank_pkg::DIR_RIGHT;
				else
					is_move = 1'b0;
				if (is_move) begin
					step_point(m_tank[p].x, m_tank[p].y, d, `TANK_STEP, nx, ny);
					m_tank[p].dir = d;  // Turns even when held
					if (nx >= `TANK_HALF && nx <= `TANK_ARENA_W - 1 - `TANK_HALF &&
						ny >= `TANK_HALF && ny <= `TANK_ARENA_H - 1 - `TANK_HALF &&
						!hits_barrier(nx, ny, `TANK_HALF)) begin
						m_tank[p].x = tank_pkg::coord_t'(nx);
						m_tank[p].y = tank_pkg::coord_t'(ny);
					end
				end
			end
		end
	endtask

	always @(posedge frame_clk or negedge arst_n) begin
		if (!arst_n)
			reset_model();
		else
			advance_model();
	end

	// ==================================================================
	// Checks and timeout
	// ==================================================================
	task automatic compare(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("mismatch %s: got 0x%0h, expected 0x%0h (cycle %0d)",
				name, got, expected, cycle_count);
			$display("=== FAIL ===");
			$fatal(1, "output check failed");
		end
	endtask

	task automatic check_outputs();
		tank_pkg::tank_state_t   got_tank [2];
		tank_pkg::bullet_state_t got_bul [2];
		tank_pkg::score_t        got_score [2];
		got_tank[0]  = tank_p1;
		got_tank[1]  = tank_p2;
		got_bul[0]   = bullet_p1;
		got_bul[1]   = bullet_p2;
		got_score[0] = score_p1;
		got_score[1] = score_p2;
		for (int p = 0; p < 2; p++) begin
			compare($sformatf("tank_p%0d", p + 1), got_tank[p], m_tank[p]);
			if (m_fired[p])
				compare($sformatf("bullet_p%0d", p + 1), got_bul[p], m_bul[p]);
			else
				compare($sformatf("bullet_p%0d.active", p + 1), got_bul[p].active, 1'b0);
			compare($sformatf("score_p%0d", p + 1), got_score[p], m_score[p]);
		end
		compare("new_round", new_round, shot_lands(0) || shot_lands(1));
	endtask

	always @(negedge frame_clk)
		check_outputs();  // Outputs settled half a period after the edge

	// Bound assertion failures
	always @(negedge frame_clk) begin
		if (dut.u_sva.assert_failures != 0) begin
			$display("bound assertion failed by cycle %0d", cycle_count);
			$display("=== FAIL ===");
			$fatal(1, "assertion failure");
		end
	end

	always @(posedge frame_clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: test did not finish within %0d cycles", cycle_limit);
			$display("=== FAIL ===");
			$fatal(1, "timeout");
		end
	end

	// ==================================================================
	// Stimulus
	// ==================================================================
	task automatic drive(input tank_pkg::keycode_t m1, input tank_pkg::keycode_t m2,
		input tank_pkg::keycode_t f1, input tank_pkg::keycode_t f2);
		@(posedge frame_clk);
		key_p1_move <= m1;
		key_p2_move <= m2;
		key_p1_fire <= f1;
		key_p2_fire <= f2;
	endtask

	function automatic tank_pkg::keycode_t move_choice(input int p);
		case ($urandom_range(0, 9))
			0, 1:    return up_key[p];
			2, 3:    return down_key[p];
			4, 5:    return left_key[p];
			6, 7:    return right_key[p];
			default: return tank_pkg::keycode_t'($urandom);  // Noise code
		endcase
	endfunction

	function automatic tank_pkg::keycode_t fire_choice(input int p);
		if ($urandom_range(0, 3) == 0)
			return fire_code[p];
		return tank_pkg::keycode_t'($urandom);
	endfunction

	initial begin
		arst_n      = 1'b0;
		key_p1_move = 8'h00;
		key_p2_move = 8'h00;
		key_p1_fire = 8'h00;
		key_p2_fire = 8'h00;
		void'($urandom(22));
		reset_model();
		repeat (3) @(posedge frame_clk);
		arst_n <= 1'b1;

		// Both climb to y 150, P1 turns right and shoots across
		repeat (45) drive(up_key[0], up_key[1], 8'h00, 8'h00);
		drive(right_key[0], 8'h00, 8'h00, 8'h00);
		drive(8'h00, 8'h00, fire_code[0], 8'h00);
		@(negedge frame_clk);
		while (!new_round)
			@(negedge frame_clk);
		@(negedge frame_clk);
		compare("score_p1", score_p1, 8'd1);
		compare("tank_p1", tank_p1, start_tank(0));
		compare("tank_p2", tank_p2, start_tank(1));
		compare("bullet_p1.active", bullet_p1.active, 1'b0);
		compare("bullet_p2.active", bullet_p2.active, 1'b0);

		// P1 into the left edge, P2 into the centre barrier behind its shot
		repeat (2) drive(left_key[0], left_key[1], 8'h00, fire_code[1]);
		repeat (98) drive(left_key[0], left_key[1], 8'h00, 8'h00);
		// Step aside, then turn back into the edge and the barrier
		drive(down_key[0], up_key[1], 8'h00, 8'h00);
		drive(left_key[0], left_key[1], 8'h00, 8'h00);
		repeat (2) drive(8'h00, 8'h00, fire_code[0], 8'h00);  // Shot off the left edge
		repeat (4) drive(8'h00, 8'h00, 8'h00, 8'h00);

		for (int i = 0; i < random_cycles; i++)
			drive(move_choice(0), move_choice(1), fire_choice(0), fire_choice(1));
		@(negedge frame_clk);

		if (dut.u_sva.assert_failures == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			$display("bound assertions failed %0d times", dut.u_sva.assert_failures);
			$display("=== FAIL ===");
			$fatal(1, "assertion failures");
		end
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+source
source/tank_pkg.sv
source/tank_motion.sv
source/bullet_motion.sv
source/barrier_field.sv
source/hit_detector.sv
source/tank_game_top.sv
verification/tank_game_sva.sv
verification/tank_game_tb.sv

// ==== Bender.yml ====
package:
  name: tank_game

sources:
  - include_dirs:
      - source
    files:
      - source/tank_pkg.sv
      - source/tank_motion.sv
      - source/bullet_motion.sv
      - source/barrier_field.sv
      - source/hit_detector.sv
      - source/tank_game_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/tank_game_sva.sv
      - verification/tank_game_tb.sv
